// ==== filelist.f ====
logic/blk_cipher_pkg.sv
logic/blk_ctrl_pkg.sv
logic/blk_stream_if.sv
logic/cipher_if.sv
logic/block_cipher_core.sv
logic/cipher_input_stage.sv
logic/cipher_controller.sv
logic/cipher_mode_unit.sv
logic/cipher_output_stage.sv
logic/cipher_top.sv
tb/cipher_tb.sv

// ==== logic/blk_cipher_pkg.sv ====
package blk_cipher_pkg;

	// ========================================================================
	// Datapath geometry
	// ========================================================================

	// Width of one word on the input and output buses
	localparam int WORD_W = 32;

	// Width of one cipher block
	localparam int BLK_W = 128;

	// Bus words that make up one block
	localparam int WORDS_PER_BLK = BLK_W / WORD_W;

	// Left rotation applied to the block in every encryption round
	localparam int ROT_AMT = 13;

	typedef logic [WORD_W-1:0] word_t;

	typedef logic [BLK_W-1:0] block_t;

	// Key is as wide as a block, round keys are rotations of it
	typedef logic [BLK_W-1:0] key_t;

endpackage

// ==== logic/blk_ctrl_pkg.sv ====
package blk_ctrl_pkg;

	// ========================================================================
	// Command block layout
	// ========================================================================

	// Mode of operation field
	localparam int CMD_MODE_LSB = 0;
	localparam int CMD_MODE_W = 2;

	// Set for decryption, clear for encryption
	localparam int CMD_DECRYPT_BIT = 2;

	// Mode code 3 is unused and runs as ECB
	typedef enum logic [1:0] {
		ECB = 2'd0,
		CBC = 2'd1,
		CTR = 2'd2
	} cipher_mode_e;

	// Message sequencing in the controller
	typedef enum logic [1:0] {
		GET_CMD,
		GET_KEY,
		PAYLOAD
	} ctrl_state_e;

endpackage

// ==== logic/blk_stream_if.sv ====
interface blk_stream_if;

	logic valid;
	logic ready;
	blk_cipher_pkg::block_t blk;
	logic last;

	// Block moves on an edge with valid and ready both high
	modport src (
		output valid,
		output blk,
		output last,
		input ready
	);

	modport dst (
		input valid,
		input blk,
		input last,
		output ready
	);

endinterface

// ==== logic/block_cipher_core.sv ====
module block_cipher_core #(
	parameter int ROUNDS = 4
) (
	input logic clk,
	input logic reset,
	input blk_cipher_pkg::key_t key,
	cipher_if.core req
);

	localparam int STEP_W = (ROUNDS > 1) ? $clog2(ROUNDS) : 1;
	localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(ROUNDS - 1);

	blk_cipher_pkg::block_t state_blk;
	logic [STEP_W-1:0] step;
	logic dec;
	logic busy;
	logic done;

	logic launch;
	logic advance;
	logic cur_dec;
	logic last_step;
	logic [STEP_W-1:0] cur_step;
	logic [STEP_W-1:0] rnd_idx;
	blk_cipher_pkg::block_t cur_blk;
	blk_cipher_pkg::key_t rnd_key;
	blk_cipher_pkg::block_t rnd_out;

	function automatic blk_cipher_pkg::block_t rotl(
		blk_cipher_pkg::block_t v,
		int unsigned n
	);
		return (v << n) | (v >> (blk_cipher_pkg::BLK_W - n));
	endfunction

	// First round runs on the start edge straight from din
	assign launch = req.start && !busy;
	assign advance = busy && !done;

	assign cur_blk = busy ? state_blk : req.din;
	assign cur_dec = busy ? dec : req.decrypt;
	assign cur_step = busy ? step : '0;
	assign last_step = (cur_step == LAST_STEP);

	// Decryption walks the round keys backwards
	assign rnd_idx = cur_dec ? (LAST_STEP - cur_step) : cur_step;
	assign rnd_key = rotl(key, (blk_cipher_pkg::WORD_W * int'(rnd_idx)) % blk_cipher_pkg::BLK_W);

	always_comb begin
		if (cur_dec)
			rnd_out = rotl(cur_blk, blk_cipher_pkg::BLK_W - blk_cipher_pkg::ROT_AMT) ^ rnd_key;
		else
			rnd_out = rotl(cur_blk ^ rnd_key, blk_cipher_pkg::ROT_AMT);
	end

	always_ff @(posedge clk) begin
		if (launch || advance)
			state_blk <= rnd_out;
		if (launch)
			dec <= req.decrypt;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			done <= 1'b0;
			step <= '0;
		end else begin
			if (launch)
				busy <= 1'b1;
			else if (done)
				busy <= 1'b0;
			if (launch || advance)
				step <= cur_step + 1'b1;
			done <= (launch || advance) && last_step;
		end
	end

	assign req.dout = state_blk;
	assign req.done = done;
	assign req.busy = busy;

endmodule

// ==== logic/cipher_controller.sv ====
module cipher_controller (
	input logic clk,
	input logic reset,
	blk_stream_if.dst blk_in,
	blk_stream_if.src payload,
	output blk_cipher_pkg::key_t key,
	output blk_ctrl_pkg::cipher_mode_e mode,
	output logic decrypt,
	input logic msg_done
);

	blk_ctrl_pkg::ctrl_state_e state;
	logic [blk_ctrl_pkg::CMD_MODE_W-1:0] cmd_mode;
	blk_ctrl_pkg::cipher_mode_e cmd_mode_dec;
	logic accept;

	// ========================================================================
	// Stream routing
	// ========================================================================

	// Command and key blocks are consumed here, payload goes downstream
	assign blk_in.ready = (state == blk_ctrl_pkg::PAYLOAD) ? payload.ready : 1'b1;
	assign payload.valid = (state == blk_ctrl_pkg::PAYLOAD) && blk_in.valid;
	assign payload.blk = blk_in.blk;
	assign payload.last = blk_in.last;

	assign accept = blk_in.valid && blk_in.ready;

	// ========================================================================
	// Command decode
	// ========================================================================

	assign cmd_mode = blk_in.blk[blk_ctrl_pkg::CMD_MODE_LSB +: blk_ctrl_pkg::CMD_MODE_W];

	always_comb begin
		case (cmd_mode)
			blk_ctrl_pkg::CBC: cmd_mode_dec = blk_ctrl_pkg::CBC;
			blk_ctrl_pkg::CTR: cmd_mode_dec = blk_ctrl_pkg::CTR;
			default: cmd_mode_dec = blk_ctrl_pkg::ECB;
		endcase
	end

	always_ff @(posedge clk) begin
		if (state == blk_ctrl_pkg::GET_KEY && accept)
			key <= blk_in.blk;
	end

	// ========================================================================
	// Message FSM
	// ========================================================================

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= blk_ctrl_pkg::GET_CMD;
			mode <= blk_ctrl_pkg::ECB;
			decrypt <= 1'b0;
		end else begin
			case (state)
				blk_ctrl_pkg::GET_CMD: begin
					if (accept) begin
						mode <= cmd_mode_dec;
						decrypt <= blk_in.blk[blk_ctrl_pkg::CMD_DECRYPT_BIT];
						state <= blk_ctrl_pkg::GET_KEY;
					end
				end
				blk_ctrl_pkg::GET_KEY: begin
					if (accept)
						state <= blk_ctrl_pkg::PAYLOAD;
				end
				blk_ctrl_pkg::PAYLOAD: begin
					// Last result has left the mode unit
					if (msg_done)
						state <= blk_ctrl_pkg::GET_CMD;
				end
				default: state <= blk_ctrl_pkg::GET_CMD;
			endcase
		end
	end

endmodule

// ==== logic/cipher_if.sv ====
interface cipher_if;

	logic start;
	logic decrypt;
	blk_cipher_pkg::block_t din;
	blk_cipher_pkg::block_t dout;
	logic done;
	logic busy;

	// start is a single-cycle pulse, only while busy is low
	modport requester (
		output start,
		output decrypt,
		output din,
		input dout,
		input done,
		input busy
	);

	modport core (
		input start,
		input decrypt,
		input din,
		output dout,
		output done,
		output busy
	);

endinterface

// ==== logic/cipher_input_stage.sv ====
module cipher_input_stage (
	input logic clk,
	input logic reset,
	input logic in_data_wren,
	input logic in_tlast,
	input blk_cipher_pkg::word_t in_data,
	output logic in_busy,
	blk_stream_if.src blk_out
);

	localparam int CNT_W = $clog2(blk_cipher_pkg::WORDS_PER_BLK);
	localparam logic [CNT_W-1:0] LAST_WORD = CNT_W'(blk_cipher_pkg::WORDS_PER_BLK - 1);

	blk_cipher_pkg::block_t acc;
	blk_cipher_pkg::block_t next_acc;
	logic [CNT_W-1:0] word_cnt;
	blk_cipher_pkg::block_t hold_blk;
	logic hold_last;
	logic hold_valid;
	logic take;

	// Words arriving while the buffer is full are dropped
	assign take = in_data_wren && !hold_valid;

	// New word enters at the top, so the first word ends up lowest
	assign next_acc = {in_data, acc[blk_cipher_pkg::BLK_W-1:blk_cipher_pkg::WORD_W]};

	always_ff @(posedge clk) begin
		if (take)
			acc <= next_acc;
		if (take && word_cnt == LAST_WORD) begin
			hold_blk <= next_acc;
			hold_last <= in_tlast;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			word_cnt <= '0;
			hold_valid <= 1'b0;
		end else begin
			if (take)
				word_cnt <= word_cnt + 1'b1;
			if (take && word_cnt == LAST_WORD)
				hold_valid <= 1'b1;
			else if (blk_out.valid && blk_out.ready)
				hold_valid <= 1'b0;
		end
	end

	assign in_busy = hold_valid;
	assign blk_out.valid = hold_valid;
	assign blk_out.blk = hold_blk;
	assign blk_out.last = hold_last;

endmodule

// ==== logic/cipher_mode_unit.sv ====
module cipher_mode_unit (
	input logic clk,
	input logic reset,
	blk_stream_if.dst payload,
	input blk_ctrl_pkg::cipher_mode_e mode,
	input logic decrypt,
	cipher_if.requester core,
	blk_stream_if.src res,
	output logic msg_done
);

	blk_cipher_pkg::block_t chain;
	blk_cipher_pkg::block_t held_blk;
	logic held_last;
	blk_cipher_pkg::block_t res_blk;
	logic res_last;
	logic res_valid;
	logic iv_pending;

	logic accept;
	logic iv_needed;
	blk_cipher_pkg::block_t core_din;
	blk_cipher_pkg::block_t result;

	// One block in flight, nothing new until the result has gone
	assign payload.ready = !core.busy && !res_valid;
	assign accept = payload.valid && payload.ready;

	assign iv_needed = iv_pending && (mode == blk_ctrl_pkg::CBC || mode == blk_ctrl_pkg::CTR);

	assign core.start = accept && !iv_needed;
	// CTR only ever runs the core forwards
	assign core.decrypt = (mode == blk_ctrl_pkg::CTR) ? 1'b0 : decrypt;
	assign core.din = core_din;

	// ========================================================================
	// Chaining around the core
	// ========================================================================

	always_comb begin
		core_din = payload.blk;
		result = core.dout;
		case (mode)
			blk_ctrl_pkg::CBC: begin
				if (decrypt)
					result = core.dout ^ chain;
				else
					core_din = payload.blk ^ chain;
			end
			blk_ctrl_pkg::CTR: begin
				core_din = chain;
				result = core.dout ^ held_blk;
			end
			default: begin
				core_din = payload.blk;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (accept && iv_needed)
			chain <= payload.blk;
		if (core.start) begin
			held_blk <= payload.blk;
			held_last <= payload.last;
		end
		if (core.done) begin
			res_blk <= result;
			res_last <= held_last;
			if (mode == blk_ctrl_pkg::CBC)
				chain <= decrypt ? held_blk : core.dout;
			else if (mode == blk_ctrl_pkg::CTR)
				chain <= chain + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			res_valid <= 1'b0;
			iv_pending <= 1'b1;
		end else begin
			if (core.done)
				res_valid <= 1'b1;
			else if (res.valid && res.ready)
				res_valid <= 1'b0;
			if (msg_done)
				iv_pending <= 1'b1;
			else if (accept && iv_needed)
				iv_pending <= 1'b0;
		end
	end

	assign res.valid = res_valid;
	assign res.blk = res_blk;
	assign res.last = res_last;

	assign msg_done = res.valid && res.ready && res.last;

endmodule

// ==== logic/cipher_output_stage.sv ====
module cipher_output_stage (
	input logic clk,
	input logic reset,
	blk_stream_if.dst blk_in,
	output logic out_tvalid,
	input logic out_tready,
	output blk_cipher_pkg::word_t out_tdata,
	output logic out_tlast
);

	localparam int IDX_W = $clog2(blk_cipher_pkg::WORDS_PER_BLK);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(blk_cipher_pkg::WORDS_PER_BLK - 1);

	blk_cipher_pkg::block_t buf_blk;
	logic buf_last;
	logic full;
	logic [IDX_W-1:0] idx;
	logic word_xfer;

	assign blk_in.ready = !full;
	assign word_xfer = out_tvalid && out_tready;

	always_ff @(posedge clk) begin
		if (blk_in.valid && blk_in.ready) begin
			buf_blk <= blk_in.blk;
			buf_last <= blk_in.last;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			full <= 1'b0;
			idx <= '0;
		end else if (blk_in.valid && blk_in.ready) begin
			full <= 1'b1;
			idx <= '0;
		end else if (word_xfer) begin
			idx <= idx + 1'b1;
			if (idx == LAST_IDX)
				full <= 1'b0;
		end
	end

	// Lowest word goes out first
	assign out_tvalid = full;
	assign out_tdata = buf_blk[idx*blk_cipher_pkg::WORD_W +: blk_cipher_pkg::WORD_W];
	assign out_tlast = full && buf_last && (idx == LAST_IDX);

endmodule

// ==== logic/cipher_top.sv ====
module cipher_top #(
	parameter int ROUNDS = 4
) (
	input logic clk,
	input logic reset,
	input logic in_data_wren,
	input logic in_tlast,
	input blk_cipher_pkg::word_t in_data,
	output logic in_busy,
	output logic out_tvalid,
	input logic out_tready,
	output blk_cipher_pkg::word_t out_tdata,
	output logic out_tlast
);

	blk_cipher_pkg::key_t key;
	blk_ctrl_pkg::cipher_mode_e mode;
	logic decrypt;
	logic msg_done;

	blk_stream_if in_blk ();
	blk_stream_if payload_blk ();
	blk_stream_if out_blk ();
	cipher_if core_req ();

	// ========================================================================
	// Input words to blocks, then command, key and payload routing
	// ========================================================================

	cipher_input_stage i_input_stage (
		.clk(clk),
		.reset(reset),
		.in_data_wren(in_data_wren),
		.in_tlast(in_tlast),
		.in_data(in_data),
		.in_busy(in_busy),
		.blk_out(in_blk)
	);

	cipher_controller i_controller (
		.clk(clk),
		.reset(reset),
		.blk_in(in_blk),
		.payload(payload_blk),
		.key(key),
		.mode(mode),
		.decrypt(decrypt),
		.msg_done(msg_done)
	);

	// ========================================================================
	// Modes of operation, cipher core and output words
	// ========================================================================

	cipher_mode_unit i_mode_unit (
		.clk(clk),
		.reset(reset),
		.payload(payload_blk),
		.mode(mode),
		.decrypt(decrypt),
		.core(core_req),
		.res(out_blk),
		.msg_done(msg_done)
	);

	block_cipher_core #(
		.ROUNDS(ROUNDS)
	) i_core (
		.clk(clk),
		.reset(reset),
		.key(key),
		.req(core_req)
	);

	cipher_output_stage i_output_stage (
		.clk(clk),
		.reset(reset),
		.blk_in(out_blk),
		.out_tvalid(out_tvalid),
		.out_tready(out_tready),
		.out_tdata(out_tdata),
		.out_tlast(out_tlast)
	);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and check the log
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f filelist.f --top-module cipher_tb -o cipher_sim \
	|| { echo "Build failed"; exit 1; }
./obj_dir/cipher_sim > sim.log 2>&1
cat sim.log
grep -q "Errors found" sim.log && { echo "Simulation FAILED"; exit 1; } || { echo "Simulation passed"; exit 0; }

// ==== tb/cipher_tb.sv ====
module cipher_tb;

	localparam int ROUNDS = 4;
	localparam int CLK_PERIOD = 40;
	localparam int NUM_MSGS = 40;
	localparam int MAX_BLKS = 4;

	logic clk;
	logic reset;
	logic in_data_wren;
	logic in_tlast;
	blk_cipher_pkg::word_t in_data;
	logic in_busy;
	logic out_tvalid;
	logic out_tready;
	blk_cipher_pkg::word_t out_tdata;
	logic out_tlast;

	// Expected output words in arrival order
	blk_cipher_pkg::word_t exp_data[$];
	logic exp_last[$];
	int words_seen;

	logic [1:0] mode;
	logic dec;
	logic round_trip;
	int nblk;
	blk_cipher_pkg::key_t key;
	blk_cipher_pkg::block_t iv;
	blk_cipher_pkg::block_t cmd;
	blk_cipher_pkg::block_t pay[MAX_BLKS];
	blk_cipher_pkg::block_t res[MAX_BLKS];
	blk_cipher_pkg::block_t prev_pay[MAX_BLKS];
	blk_cipher_pkg::block_t prev_res[MAX_BLKS];

	cipher_top #(
		.ROUNDS(ROUNDS)
	) i_cipher_top (
		.clk(clk),
		.reset(reset),
		.in_data_wren(in_data_wren),
		.in_tlast(in_tlast),
		.in_data(in_data),
		.in_busy(in_busy),
		.out_tvalid(out_tvalid),
		.out_tready(out_tready),
		.out_tdata(out_tdata),
		.out_tlast(out_tlast)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ========================================================================
	// Reference model
	// ========================================================================

	function automatic blk_cipher_pkg::block_t rot_left(blk_cipher_pkg::block_t v, int n);
		logic [255:0] dbl;
		dbl = {v, v} << n;
		return dbl[255:128];
	endfunction

	function automatic blk_cipher_pkg::block_t encrypt_block(blk_cipher_pkg::block_t b,
			blk_cipher_pkg::key_t k);
		for (int r = 0; r < ROUNDS; r++)
			b = rot_left(b ^ rot_left(k, (32 * r) % 128), 13);
		return b;
	endfunction

	// Rotating left by 115 is a right rotation by 13
	function automatic blk_cipher_pkg::block_t decrypt_block(blk_cipher_pkg::block_t b,
			blk_cipher_pkg::key_t k);
		for (int r = ROUNDS - 1; r >= 0; r--)
			b = rot_left(b, 115) ^ rot_left(k, (32 * r) % 128);
		return b;
	endfunction

	function automatic blk_cipher_pkg::block_t rand_block();
		return {$urandom, $urandom, $urandom, $urandom};
	endfunction

	task automatic apply_modes();
		blk_cipher_pkg::block_t chain;
		chain = iv;
		for (int i = 0; i < nblk; i++) begin
			case (mode)
				2'd1: begin
					if (dec) begin
						res[i] = decrypt_block(pay[i], key) ^ chain;
						chain = pay[i];
					end else begin
						res[i] = encrypt_block(pay[i] ^ chain, key);
						chain = res[i];
					end
				end
				2'd2: begin
					res[i] = pay[i] ^ encrypt_block(chain, key);
					chain = chain + 1'b1;
				end
				default: res[i] = dec ? decrypt_block(pay[i], key) : encrypt_block(pay[i], key);
			endcase
		end
	endtask

	task automatic queue_expected();
		for (int i = 0; i < nblk; i++) begin
			for (int j = 0; j < 4; j++) begin
				exp_data.push_back(res[i][32*j +: 32]);
				exp_last.push_back(i == nblk - 1 && j == 3);
			end
		end
	endtask

	// ========================================================================
	// Input driver
	// ========================================================================

	task automatic send_word(input blk_cipher_pkg::word_t w, input logic last);
		int gap;
		gap = ($urandom % 4 == 0) ? ($urandom % 3 + 1) : 0;
		repeat (gap) begin
			@(posedge clk);
			in_data_wren <= 1'b0;
		end
		@(posedge clk);
		in_data <= w;
		in_tlast <= last;
		in_data_wren <= 1'b1;
	endtask

	task automatic send_block(input blk_cipher_pkg::block_t b, input logic last);
		for (int i = 0; i < 4; i++)
			send_word(b[32*i +: 32], last && i == 3);
		@(posedge clk);
		in_data_wren <= 1'b0;
		// Buffer fills on the edge above, wait until it drains
		@(posedge clk);
		while (in_busy)
			@(posedge clk);
	endtask

	task automatic compare_word();
		blk_cipher_pkg::word_t exp_w;
		logic exp_l;
		exp_w = exp_data.pop_front();
		exp_l = exp_last.pop_front();
		assert (out_tdata == exp_w && out_tlast == exp_l) words_seen++;
		else begin
			$display("[FAIL] %0t: word %0d data %h last %b, expected %h last %b",
				$time, words_seen, out_tdata, out_tlast, exp_w, exp_l);
			$display("Errors found");
			$fatal(1, "output word mismatch");
		end
	endtask

	always @(posedge clk)
		out_tready <= ($urandom % 4) != 0;

	always @(posedge clk) begin
		if (!reset && out_tvalid && out_tready) begin
			assert (exp_data.size() != 0) compare_word();
			else begin
				$display("Output word %h arrived when no word was expected", out_tdata);
				$display("Errors found");
				$fatal(1, "unexpected output word");
			end
		end
	end

	initial begin
		#(NUM_MSGS * 6 * blk_cipher_pkg::WORDS_PER_BLK * 20 * CLK_PERIOD);
		$display("Timeout: %0d output words still missing", exp_data.size());
		$display("Errors found");
		$fatal(1, "watchdog timeout");
	end

	// ========================================================================
	// Main sequence
	// ========================================================================

	initial begin
		void'($urandom(32'h9d29));
		words_seen = 0;
		reset = 1'b1;
		in_data_wren = 1'b0;
		in_tlast = 1'b0;
		in_data = '0;
		out_tready = 1'b0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		assert (!out_tvalid && !in_busy) else begin
			$display("out_tvalid or in_busy high right after reset");
			$display("Errors found");
			$fatal(1, "reset state wrong");
		end
		for (int msg = 0; msg < NUM_MSGS; msg++) begin
			round_trip = (msg > 0) && ($urandom % 3 == 0);
			if (round_trip) begin
				// Same key, mode and IV on the last output, which must give back its input
				dec = !dec;
				pay = prev_res;
				res = prev_pay;
			end else begin
				mode = 2'($urandom % 4);
				dec = 1'($urandom % 2);
				key = rand_block();
				iv = rand_block();
				nblk = $urandom % MAX_BLKS + 1;
				for (int i = 0; i < MAX_BLKS; i++)
					pay[i] = rand_block();
				apply_modes();
			end
			queue_expected();
			cmd = rand_block();
			cmd[blk_ctrl_pkg::CMD_MODE_LSB +: blk_ctrl_pkg::CMD_MODE_W] = mode;
			cmd[blk_ctrl_pkg::CMD_DECRYPT_BIT] = dec;
			send_block(cmd, 1'b0);
			send_block(key, 1'b0);
			if (mode == 2'd1 || mode == 2'd2)
				send_block(iv, 1'b0);
			for (int i = 0; i < nblk; i++)
				send_block(pay[i], i == nblk - 1);
			prev_pay = pay;
			prev_res = res;
		end
		while (exp_data.size() != 0)
			@(posedge clk);
		// Extra output words would show up here
		repeat (40) @(posedge clk);
		$display("No errors");
		$finish;
	end

endmodule
